// ==== rtl/i2c_seq_cmd_pkg.sv ====
// Command-port map and storage types of the frame-scheduled I2C sequencer
// (address decode, control word bits, page and word types)
`default_nettype none

package i2c_seq_cmd_pkg;

    typedef logic [10:0] cmd_addr_t;            // command-port address

    // absolute and relative windows match on [10:4], low nibble is page/offset
    localparam cmd_addr_t abs_base  = 11'h410;  // write to absolute frame page
    localparam cmd_addr_t rel_base  = 11'h420;  // write relative to current frame
    localparam cmd_addr_t ctrl_addr = 11'h402;  // control word

    localparam int num_pages      = 16;         // frame pages
    localparam int words_per_page = 64;         // command words per page

    typedef logic [$clog2(num_pages)-1:0]      page_t;     // frame page number
    typedef logic [$clog2(words_per_page)-1:0] wptr_t;     // word pointer in a page
    typedef logic [31:0]                       cmd_word_t; // {sa, reg, data_hi, data_lo}

    // control word bits
    localparam int ctrl_reset_bit   = 14;       // clear all pages, stop bus
    localparam int ctrl_run_bit     = 13;       // run value below is valid
    localparam int ctrl_run_val_bit = 12;       // 1 run, 0 stop

    localparam int cmd_bytes = 6;               // AL, AH, D0..D3

endpackage

`default_nettype wire

// ==== rtl/i2c_bus_pkg.sv ====
// I2C bus timing and word framing for the write engine
`default_nettype none

package i2c_bus_pkg;

    localparam int quarter_cycles = 25;         // mclk cycles per quarter SCL period
    localparam int bytes_per_word = 4;          // sa, reg, data_hi, data_lo
    localparam int bits_per_byte  = 9;          // 8 data bits + ACK slot

    // counter widths
    localparam int quarter_w = $clog2(quarter_cycles);
    localparam int bit_w     = $clog2(bits_per_byte);
    localparam int byte_w    = $clog2(bytes_per_word);

endpackage

`default_nettype wire

// ==== rtl/sync_dp_ram.sv ====
// Simple dual-port RAM, one write port and one registered read port
`default_nettype none

module sync_dp_ram #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 16
) (
    input  wire                     mclk,
    input  wire                     we,
    input  wire [$clog2(depth)-1:0] waddr,
    input  wire payload_t           wdata,
    input  wire [$clog2(depth)-1:0] raddr,
    output payload_t                rdata      // one cycle after raddr
);

    payload_t mem [depth];

    always_ff @(posedge mclk) begin
        if (we) mem[waddr] <= wdata;
        rdata <= mem[raddr];                    // read-before-write on collision
    end

endmodule

`default_nettype wire

// ==== rtl/cmd_deserializer.sv ====
// Command deserializer
// Collects AL, AH, D0..D3 from the byte-serial port and decodes the target
`default_nettype none

module cmd_deserializer
    import i2c_seq_cmd_pkg::*;
(
    input  wire        mclk,
    input  wire        reset_cmd,
    input  wire  [7:0] cmd_ad,      // address/data byte
    input  wire        cmd_stb,     // marks AL
    output page_t      cmd_addr,    // low address nibble
    output cmd_word_t  cmd_data,
    output logic       we_abs,
    output logic       we_rel,
    output logic       we_ctrl
);

    logic [2:0]             byte_cnt;   // index of the byte now on cmd_ad, 0 idle
    logic [8*cmd_bytes-1:0] shreg;      // bytes shift in from the top
    logic [8*cmd_bytes-1:0] shreg_nxt;
    logic                   last_byte;  // D3 on the port
    cmd_addr_t              addr_full;

    assign shreg_nxt = {cmd_ad, shreg[8*cmd_bytes-1:8]};
    assign last_byte = (byte_cnt == 3'(cmd_bytes - 1));
    assign addr_full = shreg_nxt[$bits(cmd_addr_t)-1:0]; // {AH, AL} once complete

    always_ff @(posedge mclk) begin
        if (reset_cmd) begin
            byte_cnt <= '0;
            we_abs   <= 1'b0;
            we_rel   <= 1'b0;
            we_ctrl  <= 1'b0;
        end else begin
            // one strobe, the cycle after D3
            we_abs  <= last_byte && (addr_full[10:4] == abs_base[10:4]);
            we_rel  <= last_byte && (addr_full[10:4] == rel_base[10:4]);
            we_ctrl <= last_byte && (addr_full == ctrl_addr);
            if (cmd_stb) begin
                byte_cnt <= 3'd1;               // AH comes next
            end else if (last_byte) begin
                byte_cnt <= '0;
            end else if (byte_cnt != '0) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    // payload, held until the next command completes
    always_ff @(posedge mclk) begin
        if (cmd_stb || (byte_cnt != '0)) shreg <= shreg_nxt;
        if (last_byte) begin
            cmd_addr <= addr_full[3:0];
            cmd_data <= shreg_nxt[8*cmd_bytes-1:16]; // D3 ends up as msb
        end
    end

endmodule

`default_nettype wire

// ==== rtl/frame_page_scheduler.sv ====
// Frame page scheduler
// Stores command words into 16 frame pages, advances pages on frame_sync
// and feeds the pages up to the current frame to the I2C write engine
`default_nettype none

module frame_page_scheduler
    import i2c_seq_cmd_pkg::*;
(
    input  wire            mclk,
    input  wire            reset_cmd,
    input  wire page_t     cmd_addr,
    input  wire cmd_word_t cmd_data,
    input  wire            we_abs,
    input  wire            we_rel,
    input  wire            we_ctrl,
    input  wire            frame_sync,
    input  wire            word_active,
    output logic           word_start,
    output cmd_word_t      word_data,
    output page_t          frame_num,      // current write page
    output logic           run_en,
    output logic           busy
);

    logic                 wen;            // any command write
    logic [1:0]           wen_hist;       // wen 1 and 2 cycles back
    logic [3:0]           busy_cnt;
    logic                 fifo_reset, run_cmd;
    logic                 reset_on;       // clearing all pages in turn
    logic                 req_adv;        // pending frame_sync
    logic                 pre_adv, adv;
    page_t                prev_page;      // page just left
    page_t                clr_page;       // page whose pointer gets cleared
    page_t                wpage_wr;       // page of the word in flight
    logic                 wr_s1, wr_s2;   // word write pipeline
    logic [num_pages-1:0] ptr_valid;      // page written since power-up
    logic                 ptr_we;
    page_t                ptr_waddr, ptr_raddr, ptr_raddr_d;
    wptr_t                ptr_wdata, ptr_rdata, ptr_count;
    page_t                page_r;         // page being drained
    wptr_t                rpointer;
    logic                 rd_valid;       // ptr_count and word_data belong to page_r/rpointer
    logic                 word_active_d;
    logic                 words_left, drained, word_done, page_step;

    assign wen     = we_abs || we_rel || we_ctrl;
    // no advance right behind a write, its page was computed from the old frame
    assign pre_adv = req_adv && !reset_on && !wen && (wen_hist == 2'b00);

    // one read port, shared; write side owns it for one cycle per word
    assign ptr_raddr = wr_s1 ? wpage_wr : page_r;
    assign ptr_count = ptr_valid[ptr_raddr_d] ? ptr_rdata : '0;
    assign ptr_we    = reset_on || adv || wr_s2;
    assign ptr_waddr = (reset_on || adv) ? clr_page : wpage_wr;
    assign ptr_wdata = (reset_on || adv) ? '0 : ptr_count + 1'b1;

    assign word_done  = word_active_d && !word_active;      // stop finished
    assign words_left = rd_valid && (rpointer != ptr_count);
    assign drained    = rd_valid && (rpointer == ptr_count);
    assign page_step  = drained && !word_active && !word_active_d && (page_r != frame_num);
    assign word_start = run_en && words_left && !word_active && !word_active_d;

    always_ff @(posedge mclk) begin
        if (reset_cmd) begin
            wen_hist   <= '0;
            busy_cnt   <= '0;
            fifo_reset <= 1'b0;
            run_cmd    <= 1'b0;
            run_en     <= 1'b0;
            reset_on   <= 1'b0;
            req_adv    <= 1'b0;
            adv        <= 1'b0;
            frame_num  <= '0;
            prev_page  <= '1;
            clr_page   <= '0;
            wr_s1      <= 1'b0;
            wr_s2      <= 1'b0;
            ptr_valid  <= '0;
        end else begin
            wen_hist <= {wen_hist[0], wen};
            if (wen) begin
                busy_cnt <= 4'hf;
            end else if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;
            end
            fifo_reset <= we_ctrl && cmd_data[ctrl_reset_bit];
            run_cmd    <= we_ctrl && cmd_data[ctrl_run_bit];
            if (fifo_reset) begin
                run_en <= 1'b0;                 // reset also stops the bus
            end else if (run_cmd) begin
                run_en <= cmd_data[ctrl_run_val_bit];
            end
            reset_on <= fifo_reset || (reset_on && (clr_page != page_t'(num_pages - 1)));
            req_adv  <= frame_sync || (req_adv && !pre_adv);
            adv      <= pre_adv;                // clear cycle of the advance
            if (fifo_reset) begin
                frame_num <= '0;
                prev_page <= '1;
                clr_page  <= '0;
            end else if (reset_on) begin
                clr_page <= clr_page + 1'b1;    // one page per cycle
            end else if (pre_adv) begin
                frame_num <= frame_num + 1'b1;
                prev_page <= frame_num;
                clr_page  <= prev_page;         // becomes the farthest future page
            end
            wr_s1 <= we_abs || we_rel;          // read page count
            wr_s2 <= wr_s1;                     // store word, bump count
            if (ptr_we) ptr_valid[ptr_waddr] <= 1'b1;
        end
    end

    always_ff @(posedge mclk) begin
        if (we_abs) begin
            // late write to the page just left goes to the current one
            wpage_wr <= (cmd_addr == prev_page) ? frame_num : cmd_addr;
        end else if (we_rel) begin
            wpage_wr <= frame_num + cmd_addr;   // modulo 16
        end
        ptr_raddr_d <= ptr_raddr;
    end

    always_ff @(posedge mclk) begin
        if (reset_cmd) begin
            page_r        <= '0;
            rpointer      <= '0;
            rd_valid      <= 1'b0;
            word_active_d <= 1'b0;
            busy          <= 1'b0;
        end else begin
            word_active_d <= word_active;
            rd_valid      <= !(wr_s1 || ptr_we || word_done || page_step);
            if (reset_on || page_step) begin
                rpointer <= '0;
            end else if (word_done) begin
                rpointer <= rpointer + 1'b1;
            end
            if (reset_on) begin
                page_r <= '0;
            end else if (page_step) begin
                page_r <= page_r + 1'b1;
            end
            busy <= word_active || reset_on || (busy_cnt != '0) ||
                    (run_en && ((rpointer != ptr_count) || (page_r != frame_num)));
        end
    end

    sync_dp_ram #(.payload_t(wptr_t), .depth(num_pages)) ptr_ram (
        .mclk  (mclk),
        .we    (ptr_we),
        .waddr (ptr_waddr),
        .wdata (ptr_wdata),
        .raddr (ptr_raddr),
        .rdata (ptr_rdata)
    );

    sync_dp_ram #(.payload_t(cmd_word_t), .depth(num_pages * words_per_page)) cmd_ram (
        .mclk  (mclk),
        .we    (wr_s2),
        .waddr ({wpage_wr, ptr_count}),
        .wdata (cmd_data),
        .raddr ({page_r, rpointer}),
        .rdata (word_data)
    );

endmodule

`default_nettype wire

// ==== rtl/i2c_write_engine.sv ====
// I2C write engine
// Sends one command word as start, four bytes with ACK slots, stop
`default_nettype none

module i2c_write_engine
    import i2c_seq_cmd_pkg::*, i2c_bus_pkg::*;
(
    input  wire            mclk,
    input  wire            reset_cmd,
    input  wire            run_en,
    input  wire            word_start,
    input  wire cmd_word_t word_data,
    output logic           word_active,
    output logic           scl_out,
    output logic           sda_out,     // SDA level, 0 only while driven
    output logic           scl_en,
    output logic           sda_en       // high when pulling SDA low
);

    typedef enum logic [1:0] {st_idle, st_start, st_bits, st_stop} state_t;

    state_t               state;
    logic [quarter_w-1:0] qcnt;         // mclk within a quarter
    logic [1:0]           phase;        // quarter within a bit
    logic [bit_w-1:0]     bit_cnt;
    logic [byte_w-1:0]    byte_cnt;
    cmd_word_t            shreg;
    logic                 qtick;
    logic                 ack_slot;
    logic                 last_byte;
    logic                 load_bit;

    assign qtick     = (qcnt == quarter_w'(quarter_cycles - 1));
    assign ack_slot  = (bit_cnt == bit_w'(bits_per_byte - 1));
    assign last_byte = (byte_cnt == byte_w'(bytes_per_word - 1));
    assign load_bit  = (state == st_bits) && qtick && (phase == 2'd0) && !ack_slot;
    assign scl_en    = run_en || word_active;  // a stop waits for the word to end
    assign sda_en    = !sda_out;

    // bit: q0 scl low, q1 scl low with new sda, q2/q3 scl high
    always_ff @(posedge mclk) begin
        if (reset_cmd) begin
            state       <= st_idle;
            qcnt        <= '0;
            phase       <= '0;
            bit_cnt     <= '0;
            byte_cnt    <= '0;
            word_active <= 1'b0;
            scl_out     <= 1'b1;
            sda_out     <= 1'b1;
        end else if (state == st_idle) begin
            qcnt  <= '0;
            phase <= '0;
            if (word_start) begin
                state       <= st_start;
                word_active <= 1'b1;
            end
        end else begin
            qcnt <= qtick ? '0 : qcnt + 1'b1;
            if (qtick) begin
                phase <= phase + 1'b1;
                case (state)
                    st_start: begin
                        if (phase == 2'd0) sda_out <= 1'b0; // start, scl high
                        if (phase == 2'd3) begin
                            scl_out  <= 1'b0;
                            bit_cnt  <= '0;
                            byte_cnt <= '0;
                            state    <= st_bits;
                        end
                    end
                    st_bits: begin
                        if (phase == 2'd0) sda_out <= ack_slot ? 1'b1 : shreg[$bits(cmd_word_t)-1];
                        if (phase == 2'd1) scl_out <= 1'b1;
                        if (phase == 2'd3) begin
                            scl_out <= 1'b0;
                            if (!ack_slot) begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end else begin
                                bit_cnt <= '0;      // ACK ignored
                                if (last_byte) begin
                                    state <= st_stop;
                                end else begin
                                    byte_cnt <= byte_cnt + 1'b1;
                                end
                            end
                        end
                    end
                    default: begin                  // st_stop
                        if (phase == 2'd0) sda_out <= 1'b0;
                        if (phase == 2'd1) scl_out <= 1'b1;
                        if (phase == 2'd2) sda_out <= 1'b1; // stop, scl high
                        if (phase == 2'd3) begin
                            state       <= st_idle;
                            word_active <= 1'b0;
                        end
                    end
                endcase
            end
        end
    end

    // word payload, msb first
    always_ff @(posedge mclk) begin
        if (word_start && (state == st_idle)) begin
            shreg <= word_data;
        end else if (load_bit) begin
            shreg <= shreg << 1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sensor_i2c_seq.sv ====
// Sensor I2C sequencer top
// Byte-serial commands in, frame-scheduled I2C register writes out
`default_nettype none

module sensor_i2c_seq
    import i2c_seq_cmd_pkg::*;
(
    input  wire        mclk,
    input  wire        reset_cmd,
    input  wire  [7:0] cmd_ad,
    input  wire        cmd_stb,
    input  wire        frame_sync,
    output logic       scl_out,
    output logic       sda_out,
    output logic       scl_en,
    output logic       sda_en,
    output logic       busy,
    output page_t      frame_num
);

    page_t     cmd_addr;
    cmd_word_t cmd_data;
    logic      we_abs;
    logic      we_rel;
    logic      we_ctrl;
    logic      word_start;
    cmd_word_t word_data;
    logic      word_active;
    logic      run_en;

    cmd_deserializer u_deser (
        .mclk      (mclk),
        .reset_cmd (reset_cmd),
        .cmd_ad    (cmd_ad),
        .cmd_stb   (cmd_stb),
        .cmd_addr  (cmd_addr),
        .cmd_data  (cmd_data),
        .we_abs    (we_abs),
        .we_rel    (we_rel),
        .we_ctrl   (we_ctrl)
    );

    frame_page_scheduler u_sched (
        .mclk        (mclk),
        .reset_cmd   (reset_cmd),
        .cmd_addr    (cmd_addr),
        .cmd_data    (cmd_data),
        .we_abs      (we_abs),
        .we_rel      (we_rel),
        .we_ctrl     (we_ctrl),
        .frame_sync  (frame_sync),
        .word_active (word_active),
        .word_start  (word_start),
        .word_data   (word_data),
        .frame_num   (frame_num),
        .run_en      (run_en),
        .busy        (busy)
    );

    i2c_write_engine u_engine (
        .mclk        (mclk),
        .reset_cmd   (reset_cmd),
        .run_en      (run_en),
        .word_start  (word_start),
        .word_data   (word_data),
        .word_active (word_active),
        .scl_out     (scl_out),
        .sda_out     (sda_out),
        .scl_en      (scl_en),
        .sda_en      (sda_en)
    );

endmodule

`default_nettype wire

// ==== verification/sensor_i2c_seq_asserts.sv ====
// Write engine checks
// Start handshake, SDA idle level and SCL enable, bound into the engine
`default_nettype none

module sensor_i2c_seq_asserts (
    input wire mclk,
    input wire reset_cmd,
    input wire run_en,
    input wire word_start,
    input wire word_active,
    input wire scl_en,
    input wire sda_en
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned start_fails = 0;
    int unsigned sda_fails   = 0;
    int unsigned scl_fails   = 0;
    int unsigned fail_total;

    assign fail_total = start_fails + sda_fails + scl_fails;   // summed by the testbench

    // a new word only when the engine is idle
    assert property (@(posedge mclk) disable iff (reset_cmd) word_start |-> !word_active)
        else begin
            start_fails++;
            $error("word_start arrived while word_active was high");
        end

    assert property (@(posedge mclk) disable iff (reset_cmd) !word_active |-> !sda_en)
        else begin
            sda_fails++;
            $error("sda_en high outside a word");
        end

    // stopped bus stays quiet until run comes back
    assert property (@(posedge mclk) disable iff (reset_cmd) !scl_en |=> (scl_en == run_en))
        else begin
            scl_fails++;
            $error("scl_en rose without run_en");
        end

endmodule

bind i2c_write_engine sensor_i2c_seq_asserts engine_asserts (
    .mclk        (mclk),
    .reset_cmd   (reset_cmd),
    .run_en      (run_en),
    .word_start  (word_start),
    .word_active (word_active),
    .scl_en      (scl_en),
    .sda_en      (sda_en)
);

`default_nettype wire

// ==== verification/tb_sensor_i2c_seq.sv ====
// Testbench for the sensor I2C sequencer
// Directed tests on the command port, with a bus monitor that rebuilds
// each word sent between start and stop
`default_nettype none

module tb_sensor_i2c_seq
    import i2c_seq_cmd_pkg::*, i2c_bus_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period   = 8;
    localparam int frame_bits   = bytes_per_word * bits_per_byte;   // ACK slots included
    localparam int word_cycles  = 4 * quarter_cycles * (frame_bits + 2);
    localparam int quiet_cycles = 8 * quarter_cycles;   // a queued word starts well inside this
    localparam int budget_words = 12;                   // 10 words sent, plus idle waits
    localparam cmd_word_t run_on     = (cmd_word_t'(1) << ctrl_run_bit) |
                                       (cmd_word_t'(1) << ctrl_run_val_bit);
    localparam cmd_word_t run_off    = cmd_word_t'(1) << ctrl_run_bit;
    localparam cmd_word_t fifo_clear = cmd_word_t'(1) << ctrl_reset_bit;

    logic       mclk = 1'b0;
    logic       reset_cmd;
    logic [7:0] cmd_ad;
    logic       cmd_stb;
    logic       frame_sync;
    logic       scl_out;
    logic       sda_out;
    logic       scl_en;
    logic       sda_en;
    logic       busy;
    page_t      frame_num;

    logic        scl_line, sda_line;            // open-drain lines, released reads 1
    logic        scl_prev = 1'b1;
    logic        sda_prev = 1'b1;
    logic        in_frame = 1'b0;
    int          bit_idx;
    logic [31:0] shift_word;
    int          start_cnt  = 0;
    int          mon_errors = 0;
    cmd_word_t   rx_q [$];                      // words seen on the bus
    cmd_word_t   exp_q [$];                     // words the next check waits for
    int          rx_next = 0;
    int          errors  = 0;
    page_t       exp_frame = '0;
    logic [15:0] lfsr = 16'd43542;

    sensor_i2c_seq dut (
        .mclk       (mclk),
        .reset_cmd  (reset_cmd),
        .cmd_ad     (cmd_ad),
        .cmd_stb    (cmd_stb),
        .frame_sync (frame_sync),
        .scl_out    (scl_out),
        .sda_out    (sda_out),
        .scl_en     (scl_en),
        .sda_en     (sda_en),
        .busy       (busy),
        .frame_num  (frame_num)
    );

    always #(clk_period / 2) mclk = ~mclk;

    assign scl_line = scl_en ? scl_out : 1'b1;
    assign sda_line = sda_en ? sda_out : 1'b1;

    // bus monitor, sees pre-edge values of the registered outputs
    always @(posedge mclk) begin
        if (reset_cmd) begin
            in_frame = 1'b0;
        end else if (scl_line && scl_prev && sda_prev && !sda_line) begin
            start_cnt++;                        // sda falls, scl high
            in_frame = 1'b1;
            bit_idx  = 0;
        end else if (scl_line && scl_prev && !sda_prev && sda_line) begin
            if (in_frame && (bit_idx == frame_bits)) begin
                rx_q.push_back(shift_word);
            end else begin
                $display("ERROR at %0t: bus frame stopped after %0d of %0d bits",
                         $time, bit_idx, frame_bits);
                mon_errors++;
            end
            in_frame = 1'b0;
        end else if (in_frame && scl_line && !scl_prev && (bit_idx < frame_bits)) begin
            if ((bit_idx % bits_per_byte) != (bits_per_byte - 1)) begin
                shift_word = {shift_word[30:0], sda_line};  // ACK slot skipped
            end
            bit_idx++;
        end
        scl_prev = scl_line;
        sda_prev = sda_line;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic cmd_word_t random_word();
        cmd_word_t w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_next(lfsr);             // one step per bit
            w    = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    task automatic step();
        @(posedge mclk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // AL, AH, then D0..D3 lsb first
    task automatic send_cmd(input cmd_addr_t addr, input cmd_word_t data);
        logic [47:0] bytes;
        bytes = {data, 5'b0, addr};
        for (int i = 0; i < cmd_bytes; i++) begin
            step();
            cmd_stb = (i == 0);
            cmd_ad  = bytes[8*i +: 8];
        end
        step();
        cmd_stb = 1'b0;
        cmd_ad  = '0;
        repeat (4) step();                      // strobe, count lookup, store
    endtask

    task automatic pulse_frame_sync();
        step();
        frame_sync = 1'b1;
        step();
        frame_sync = 1'b0;
        exp_frame = exp_frame + 1'b1;           // wraps at 16
    endtask

    task automatic expect_bus_words();
        int waited;
        waited = 0;
        while ((rx_q.size() < rx_next + exp_q.size()) &&
               (waited < exp_q.size() * word_cycles + quiet_cycles)) begin
            step();
            waited++;
        end
        while (exp_q.size() > 0) begin
            if (rx_next < rx_q.size()) begin
                check_value("bus_word", rx_q[rx_next], exp_q.pop_front());
                rx_next++;
            end else begin
                $display("ERROR at %0t: bus word %h never arrived", $time, exp_q.pop_front());
                errors++;
            end
        end
    endtask

    task automatic check_no_transfer(input string when);
        int starts;
        starts = start_cnt;
        repeat (quiet_cycles) step();
        if (start_cnt != starts) begin
            $display("ERROR at %0t: unexpected bus transfer %s", $time, when);
            errors++;
        end
    endtask

    task automatic wait_not_busy();
        int waited;
        waited = 0;
        while (busy && (waited < 2 * word_cycles)) begin
            step();
            waited++;
        end
        if (busy) begin
            $display("ERROR at %0t: busy stayed high", $time);
            errors++;
        end
    endtask

    task automatic send_immediate_words();
        cmd_word_t w;
        send_cmd(ctrl_addr, run_on);
        for (int i = 0; i < 3; i++) begin
            w = random_word();
            exp_q.push_back(w);
            send_cmd(rel_base, w);              // offset 0, as soon as possible
        end
        check_value("busy", 32'(busy), 32'd1);  // words still queued
        expect_bus_words();
        wait_not_busy();
    endtask

    task automatic delay_by_frame_offset();
        cmd_word_t w [1:3];
        for (int k = 1; k <= 3; k++) begin
            w[k] = random_word();
            send_cmd(rel_base | cmd_addr_t'(k), w[k]);
        end
        check_no_transfer("before the first frame_sync");
        for (int k = 1; k <= 3; k++) begin
            pulse_frame_sync();
            exp_q.push_back(w[k]);
            expect_bus_words();
            check_value("frame_num", 32'(frame_num), 32'(exp_frame));
            check_no_transfer("ahead of its frame");
        end
        wait_not_busy();
    endtask

    task automatic place_absolute_pages();
        cmd_word_t ahead, late;
        page_t     ahead_page, left_page;
        ahead      = random_word();
        late       = random_word();
        ahead_page = exp_frame + 4'd2;
        left_page  = exp_frame - 4'd1;          // page just left
        send_cmd(abs_base | cmd_addr_t'(ahead_page), ahead);
        send_cmd(abs_base | cmd_addr_t'(left_page), late);
        exp_q.push_back(late);
        expect_bus_words();
        check_no_transfer("for a page two frames ahead");
        pulse_frame_sync();
        check_no_transfer("one frame before its page");
        pulse_frame_sync();
        exp_q.push_back(ahead);
        expect_bus_words();
        wait_not_busy();
    endtask

    task automatic hold_while_stopped();
        cmd_word_t w;
        send_cmd(ctrl_addr, run_off);
        for (int i = 0; i < 2; i++) begin
            w = random_word();
            exp_q.push_back(w);
            send_cmd(rel_base, w);
        end
        check_no_transfer("with the bus stopped");
        check_value("scl_en", 32'(scl_en), 32'd0);
        send_cmd(ctrl_addr, run_on);
        expect_bus_words();
        wait_not_busy();
    endtask

    task automatic discard_on_fifo_reset();
        send_cmd(ctrl_addr, run_off);
        send_cmd(rel_base, random_word());
        send_cmd(rel_base | cmd_addr_t'(1), random_word());
        send_cmd(ctrl_addr, fifo_clear);
        exp_frame = '0;                         // pages restart at 0
        wait_not_busy();
        send_cmd(ctrl_addr, run_on);
        check_no_transfer("after a fifo reset");
        check_value("frame_num", 32'(frame_num), 32'(exp_frame));
        wait_not_busy();
    endtask

    initial begin
        reset_cmd  = 1'b1;
        cmd_ad     = '0;
        cmd_stb    = 1'b0;
        frame_sync = 1'b0;
        repeat (5) @(posedge mclk);
        #1;
        reset_cmd = 1'b0;
        step();
        check_value("frame_num", 32'(frame_num), 32'd0);
        check_value("busy", 32'(busy), 32'd0);
        check_value("scl_en", 32'(scl_en), 32'd0);
        check_value("sda_en", 32'(sda_en), 32'd0);
        send_immediate_words();
        delay_by_frame_offset();
        place_absolute_pages();
        hold_while_stopped();
        discard_on_fifo_reset();
        errors = errors + mon_errors + int'(dut.u_engine.engine_asserts.fail_total);
        $display("error count: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // worst-case word time of all tests, doubled
    initial begin
        #(2 * budget_words * word_cycles * clk_period);
        $display("ERROR: run exceeded its time limit and was stopped");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
rtl/i2c_seq_cmd_pkg.sv
rtl/i2c_bus_pkg.sv
rtl/sync_dp_ram.sv
rtl/cmd_deserializer.sv
rtl/frame_page_scheduler.sv
rtl/i2c_write_engine.sv
rtl/sensor_i2c_seq.sv
verification/sensor_i2c_seq_asserts.sv
verification/tb_sensor_i2c_seq.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = tb_sensor_i2c_seq
FILELIST  = project.f
RUNFLAGS  = +verilator+error+limit+100
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
